// File: hdl/aluPkg.sv
// Execute stage shared types
package aluPkg;

    localparam int dataWidth   = 16;
    localparam int shamtWidth  = 4;                 // Low bits of operand b used by shifts
    localparam int regIdxWidth = 3;

    // Top three opcode bits
    typedef enum logic [2:0] {
        nopClass      = 3'b000,
        jumpClass     = 3'b001,
        arithImmClass = 3'b010,
        branchClass   = 3'b011,
        memClass      = 3'b100,
        shiftImmClass = 3'b101,
        regOpClass    = 3'b110,
        condClass     = 3'b111
    } majorClass;

    // Low two bits of each group match the minor code or funct field
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opXor  = 4'd2,
        opNand = 4'd3,
        opSll  = 4'd4,
        opSrl  = 4'd5,
        opRol  = 4'd6,
        opRor  = 4'd7,
        opSeq  = 4'd8,
        opSlt  = 4'd9,
        opSle  = 4'd10,
        opSco  = 4'd11,
        opZero = 4'd12
    } aluOp;

    typedef struct packed {
        logic [4:0]             opcode;
        logic [regIdxWidth-1:0] rs;
        logic [regIdxWidth-1:0] rd;
        logic [4:0]             imm;
    } iFormat;

    typedef struct packed {
        logic [4:0]             opcode;
        logic [regIdxWidth-1:0] rs;
        logic [regIdxWidth-1:0] rt;
        logic [regIdxWidth-1:0] rd;
        logic [1:0]             funct;
    } rFormat;

    // Same word, two field layouts
    typedef union packed {
        iFormat iFmt;
        rFormat rFmt;
    } instrWord;

    typedef struct packed {
        logic [dataWidth-1:0] rsData;
        logic [dataWidth-1:0] rtData;
    } operandPair;

    typedef struct packed {
        aluOp                 op;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
    } aluCtrl;

    typedef struct packed {
        logic [dataWidth-1:0]   result;
        logic [regIdxWidth-1:0] rd;
        logic                   writeEn;
        logic                   illegal;
    } writeBack;

endpackage

// File: hdl/claAdder16.sv
// Carry-lookahead adder
`timescale 1ns/1ps

module claAdder16 (
    input  logic [aluPkg::dataWidth-1:0] a,
    input  logic [aluPkg::dataWidth-1:0] b,
    input  logic                         cIn,
    output logic [aluPkg::dataWidth-1:0] sum,
    output logic                         cOut
);

    logic [15:0] g;                                 // Bit generate
    logic [15:0] p;                                 // Bit propagate
    logic [15:0] carry;                             // Carry into each bit
    logic [3:0]  grpG;
    logic [3:0]  grpP;
    logic [4:0]  grpC;                              // Carry into each group, plus final

    assign g = a & b;
    assign p = a ^ b;

    for (genvar i = 0; i < 4; i++) begin : gGroup
        logic [3:0] gi;
        logic [3:0] pi;
        logic       ci;

        assign gi = g[4*i +: 4];
        assign pi = p[4*i +: 4];
        assign ci = grpC[i];

        // Carries inside the group
        assign carry[4*i]   = ci;
        assign carry[4*i+1] = gi[0] | (pi[0] & ci);
        assign carry[4*i+2] = gi[1] | (pi[1] & gi[0]) | (pi[1] & pi[0] & ci);
        assign carry[4*i+3] = gi[2] | (pi[2] & gi[1]) | (pi[2] & pi[1] & gi[0])
                            | ((&pi[2:0]) & ci);

        assign grpG[i] = gi[3] | (pi[3] & gi[2]) | (pi[3] & pi[2] & gi[1])
                       | (pi[3] & pi[2] & pi[1] & gi[0]);
        assign grpP[i] = &pi;
    end

    // Second level lookahead, no ripple between groups
    assign grpC[0] = cIn;
    assign grpC[1] = grpG[0] | (grpP[0] & cIn);
    assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & cIn);
    assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                   | (grpP[2] & grpP[1] & grpP[0] & cIn);
    assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (grpP[3] & grpP[2] & grpG[1])
                   | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                   | ((&grpP) & cIn);

    assign sum  = p ^ carry;
    assign cOut = grpC[4];                          // Feeds SCO

endmodule

// File: hdl/barrelShift16.sv
// Logarithmic shifter
`timescale 1ns/1ps

module barrelShift16 (
    input  logic [aluPkg::dataWidth-1:0]  data,
    input  logic [aluPkg::shamtWidth-1:0] shamt,
    input  logic                          dir,      // High shifts left
    input  logic                          rotate,
    output logic [aluPkg::dataWidth-1:0]  shifted
);

    logic [15:0] l1;
    logic [15:0] l2;
    logic [15:0] l4;
    logic [15:0] l8;
    logic [15:0] r1;
    logic [15:0] r2;
    logic [15:0] r4;
    logic [15:0] r8;

    // Left chain, vacated bits take the wrapped bits only on rotate
    assign l1 = shamt[0] ? {data[14:0], rotate & data[15]} : data;
    assign l2 = shamt[1] ? {l1[13:0], {2{rotate}} & l1[15:14]} : l1;
    assign l4 = shamt[2] ? {l2[11:0], {4{rotate}} & l2[15:12]} : l2;
    assign l8 = shamt[3] ? {l4[7:0], {8{rotate}} & l4[15:8]} : l4;

    // Right chain
    assign r1 = shamt[0] ? {rotate & data[0], data[15:1]} : data;
    assign r2 = shamt[1] ? {{2{rotate}} & r1[1:0], r1[15:2]} : r1;
    assign r4 = shamt[2] ? {{4{rotate}} & r2[3:0], r2[15:4]} : r2;
    assign r8 = shamt[3] ? {{8{rotate}} & r4[7:0], r4[15:8]} : r4;

    assign shifted = dir ? l8 : r8;

    // Rotate only reorders bits
    always_comb begin
        assert final (!rotate || $countones(shifted) == $countones(data))
            else $error("rotate lost bits %h -> %h", data, shifted);
    end

endmodule

// File: hdl/instrDecode.sv
// Instruction decoder
`timescale 1ns/1ps

module instrDecode (
    input  aluPkg::instrWord                 instr,
    input  aluPkg::operandPair               operands,
    output aluPkg::aluCtrl                   ctrl,
    output logic [aluPkg::regIdxWidth-1:0]   rd,
    output logic                             writeEn,
    output logic                             illegal
);

    aluPkg::majorClass           opClass;
    logic [1:0]                  minor;
    logic [aluPkg::dataWidth-1:0] immSext;
    logic [aluPkg::dataWidth-1:0] immZext;

    assign opClass = aluPkg::majorClass'(instr.iFmt.opcode[4:2]);
    assign minor   = instr.iFmt.opcode[1:0];
    assign immSext = {{11{instr.iFmt.imm[4]}}, instr.iFmt.imm};
    assign immZext = {11'b0, instr.iFmt.imm};

    always_comb begin
        ctrl.op = aluPkg::opZero;
        ctrl.a  = operands.rsData;                  // Rs in every format
        ctrl.b  = operands.rtData;
        rd      = instr.iFmt.rd;
        writeEn = 1'b0;
        illegal = 1'b0;

        case (opClass)
            aluPkg::nopClass: begin
                ctrl.op = aluPkg::opZero;           // Legal, no write
            end
            aluPkg::arithImmClass: begin
                writeEn = 1'b1;
                ctrl.op = aluPkg::aluOp'({2'b00, minor});
                // Only ADDI and SUBI take a signed immediate
                ctrl.b  = minor[1] ? immZext : immSext;
            end
            aluPkg::shiftImmClass: begin
                writeEn = 1'b1;
                ctrl.op = aluPkg::aluOp'({2'b01, minor});
                ctrl.b  = immZext;
            end
            aluPkg::regOpClass: begin
                rd = instr.rFmt.rd;
                if (minor == 2'b10) begin           // Register shifts
                    writeEn = 1'b1;
                    ctrl.op = aluPkg::aluOp'({2'b01, instr.rFmt.funct});
                end else if (minor == 2'b11) begin  // Register arithmetic
                    writeEn = 1'b1;
                    ctrl.op = aluPkg::aluOp'({2'b00, instr.rFmt.funct});
                end else begin
                    illegal = 1'b1;                 // Unused minor codes
                end
            end
            aluPkg::condClass: begin
                writeEn = 1'b1;
                ctrl.op = aluPkg::aluOp'({2'b10, minor});
            end
            default: begin
                illegal = 1'b1;                     // Jump, branch, memory
            end
        endcase
    end

endmodule

// File: hdl/alu.sv
// Combinational ALU
`timescale 1ns/1ps

module alu (
    input  aluPkg::aluCtrl               ctrl,
    output logic [aluPkg::dataWidth-1:0] result
);

    logic [aluPkg::dataWidth-1:0] a;
    logic [aluPkg::dataWidth-1:0] b;
    logic [aluPkg::dataWidth-1:0] addX;
    logic [aluPkg::dataWidth-1:0] addY;
    logic [aluPkg::dataWidth-1:0] sum;
    logic                         cIn;
    logic                         cOut;
    logic                         overflow;
    logic                         lessThan;
    logic                         equal;
    logic [aluPkg::dataWidth-1:0] shifted;
    logic                         shiftLeft;
    logic                         shiftRotate;

    assign a = ctrl.a;
    assign b = ctrl.b;

    // Adder input muxing
    always_comb begin
        case (ctrl.op)
            aluPkg::opSub: begin
                addX = b;                           // b - a
                addY = ~a;
                cIn  = 1'b1;
            end
            aluPkg::opSlt, aluPkg::opSle: begin
                addX = a;                           // a - b for the compare
                addY = ~b;
                cIn  = 1'b1;
            end
            default: begin
                addX = a;
                addY = b;
                cIn  = 1'b0;
            end
        endcase
    end

    claAdder16 iAdder (
        .a    (addX),
        .b    (addY),
        .cIn  (cIn),
        .sum  (sum),
        .cOut (cOut)
    );

    assign overflow = (addX[15] == addY[15]) && (sum[15] != addX[15]);
    assign lessThan = sum[15] ^ overflow;           // Signed a < b
    assign equal    = (a == b);

    assign shiftLeft   = (ctrl.op == aluPkg::opSll) || (ctrl.op == aluPkg::opRol);
    assign shiftRotate = (ctrl.op == aluPkg::opRol) || (ctrl.op == aluPkg::opRor);

    barrelShift16 iShifter (
        .data    (a),
        .shamt   (b[aluPkg::shamtWidth-1:0]),
        .dir     (shiftLeft),
        .rotate  (shiftRotate),
        .shifted (shifted)
    );

    always_comb begin
        case (ctrl.op)
            aluPkg::opAdd,
            aluPkg::opSub:  result = sum;
            aluPkg::opXor:  result = a ^ b;
            aluPkg::opNand: result = ~(a & b);
            aluPkg::opSll,
            aluPkg::opSrl,
            aluPkg::opRol,
            aluPkg::opRor:  result = shifted;
            aluPkg::opSeq:  result = {15'b0, equal};
            aluPkg::opSlt:  result = {15'b0, lessThan};
            aluPkg::opSle:  result = {15'b0, lessThan | equal};
            aluPkg::opSco:  result = {15'b0, cOut};     // Carry of a + b
            default:        result = '0;
        endcase
    end

endmodule

// File: hdl/executeStage.sv
// Execute stage top
`timescale 1ns/1ps

module executeStage (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue,
    input  aluPkg::instrWord   instr,
    input  aluPkg::operandPair operands,
    output aluPkg::writeBack   wb,
    output logic               resultValid
);

    aluPkg::aluCtrl                 decCtrl;
    logic [aluPkg::regIdxWidth-1:0] decRd;
    logic                           decWriteEn;
    logic                           decIllegal;

    aluPkg::aluCtrl                 ctrlQ;
    logic [aluPkg::regIdxWidth-1:0] rdQ;
    logic                           writeEnQ;
    logic                           illegalQ;
    logic                           validQ;

    logic [aluPkg::dataWidth-1:0]   aluResult;

    instrDecode iDecode (
        .instr    (instr),
        .operands (operands),
        .ctrl     (decCtrl),
        .rd       (decRd),
        .writeEn  (decWriteEn),
        .illegal  (decIllegal)
    );

    // Decode register
    always_ff @(posedge clk) begin
        if (rst) begin
            validQ   <= 1'b0;
            writeEnQ <= 1'b0;
            illegalQ <= 1'b0;
        end else begin
            validQ <= issue;
            if (issue) begin
                ctrlQ    <= decCtrl;
                rdQ      <= decRd;
                writeEnQ <= decWriteEn;
                illegalQ <= decIllegal;
            end
        end
    end

    alu iAlu (
        .ctrl   (ctrlQ),
        .result (aluResult)
    );

    // Result register, holds between valid cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            wb.writeEn  <= 1'b0;
            wb.illegal  <= 1'b0;
        end else begin
            resultValid <= validQ;
            if (validQ) begin
                wb <= '{result: aluResult, rd: rdQ, writeEn: writeEnQ, illegal: illegalQ};
            end
        end
    end

    // Fixed two-cycle latency through both registers
    assert property (@(posedge clk) disable iff (rst) issue |-> ##2 resultValid)
        else $error("issued instruction produced no result two cycles later");
    assert property (@(posedge clk) disable iff (rst) !issue |-> ##2 !resultValid)
        else $error("result valid without a matching issue");

endmodule

// File: testbench/executeStageTb.sv
// Execute stage testbench
`timescale 1ns/1ps

module executeStageTb;

    logic               clk;
    logic               rst;
    logic               issue;
    aluPkg::instrWord   instr;
    aluPkg::operandPair operands;
    aluPkg::writeBack   wb;
    logic               resultValid;

    int                 seed = 7;
    int                 edgeCount = 0;
    int                 errorCount = 0;
    logic               haveLast = 1'b0;
    aluPkg::writeBack   lastWb;
    aluPkg::writeBack   wantQ[$];                   // Expected results in issue order
    int                 dueQ[$];                    // Negedge count when each is due

    executeStage i_dut (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .instr       (instr),
        .operands    (operands),
        .wb          (wb),
        .resultValid (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Tests take a few hundred cycles, so 2000 leaves ample margin
    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
        if (edgeCount >= 2000) begin
            $display("Timeout: the tests did not finish within 2000 cycles");
            stopRun();
        end
    end

    task automatic stopRun();
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            errorCount++;
            $display("FAIL %s: got %h, expected %h", name, got, want);
            stopRun();
        end
    endtask

    function automatic logic [15:0] randWord();
        return 16'($random(seed));
    endfunction

    function automatic logic [15:0] arithRef(input logic [1:0] sel, input logic [15:0] a,
                                             input logic [15:0] b);
        case (sel)
            2'd0:    return a + b;
            2'd1:    return b - a;                  // Rt or immediate minus Rs
            2'd2:    return a ^ b;
            default: return ~(a & b);
        endcase
    endfunction

    function automatic logic [15:0] shiftRef(input logic [1:0] sel, input logic [15:0] data,
                                             input logic [3:0] amt);
        logic [31:0] wide;
        wide = {data, data};
        case (sel)
            2'd0:    return data << amt;
            2'd1:    return data >> amt;
            2'd2: begin
                wide = wide << amt;                 // Upper half holds the rotated word
                return wide[31:16];
            end
            default: begin
                wide = wide >> amt;
                return wide[15:0];
            end
        endcase
    endfunction

    function automatic logic [15:0] condRef(input logic [1:0] sel, input logic [15:0] a,
                                            input logic [15:0] b);
        logic [16:0] total;
        total = {1'b0, a} + {1'b0, b};
        case (sel)
            2'd0:    return {15'b0, a == b};
            2'd1:    return {15'b0, $signed(a) < $signed(b)};
            2'd2:    return {15'b0, $signed(a) <= $signed(b)};
            default: return {15'b0, total[16]};     // Carry out of Rs plus Rt
        endcase
    endfunction

    // Reference model of one instruction
    function automatic aluPkg::writeBack expectOf(input aluPkg::instrWord w,
                                                  input aluPkg::operandPair ops);
        aluPkg::writeBack e;
        logic [2:0]       opClass;
        logic [1:0]       minor;
        logic [15:0]      immZ;
        logic [15:0]      immS;
        e       = '0;
        opClass = w.iFmt.opcode[4:2];
        minor   = w.iFmt.opcode[1:0];
        immZ    = {11'b0, w.iFmt.imm};
        immS    = {{11{w.iFmt.imm[4]}}, w.iFmt.imm};
        e.rd    = w.iFmt.rd;
        case (opClass)
            3'b000: begin
            end                                     // NOP, legal and no write
            3'b010: begin
                e.writeEn = 1'b1;
                e.result  = arithRef(minor, ops.rsData, minor[1] ? immZ : immS);
            end
            3'b101: begin
                e.writeEn = 1'b1;
                e.result  = shiftRef(minor, ops.rsData, w.iFmt.imm[3:0]);
            end
            3'b110: begin
                e.rd = w.rFmt.rd;
                if (minor == 2'b10) begin
                    e.writeEn = 1'b1;
                    e.result  = shiftRef(w.rFmt.funct, ops.rsData, ops.rtData[3:0]);
                end else if (minor == 2'b11) begin
                    e.writeEn = 1'b1;
                    e.result  = arithRef(w.rFmt.funct, ops.rsData, ops.rtData);
                end else begin
                    e.illegal = 1'b1;
                end
            end
            3'b111: begin
                e.writeEn = 1'b1;
                e.result  = condRef(minor, ops.rsData, ops.rtData);
            end
            default: e.illegal = 1'b1;              // Jump, branch, memory
        endcase
        return e;
    endfunction

    function automatic aluPkg::instrWord makeI(input logic [4:0] opcode, input logic [2:0] rs,
                                               input logic [2:0] rd, input logic [4:0] imm);
        aluPkg::instrWord w;
        w.iFmt.opcode = opcode;
        w.iFmt.rs     = rs;
        w.iFmt.rd     = rd;
        w.iFmt.imm    = imm;
        return w;
    endfunction

    function automatic aluPkg::instrWord makeR(input logic [4:0] opcode, input logic [2:0] rs,
                                               input logic [2:0] rt, input logic [2:0] rd,
                                               input logic [1:0] funct);
        aluPkg::instrWord w;
        w.rFmt.opcode = opcode;
        w.rFmt.rs     = rs;
        w.rFmt.rt     = rt;
        w.rFmt.rd     = rd;
        w.rFmt.funct  = funct;
        return w;
    endfunction

    function automatic aluPkg::operandPair makeOps(input logic [15:0] rsVal,
                                                   input logic [15:0] rtVal);
        aluPkg::operandPair ops;
        ops.rsData = rsVal;
        ops.rtData = rtVal;
        return ops;
    endfunction

    function automatic aluPkg::instrWord randomLegal();
        aluPkg::instrWord w;
        logic [15:0]      bits;
        int               pick;
        bits = randWord();
        pick = $unsigned($random(seed)) % 5;
        case (pick)
            0:       bits[15:13] = 3'b010;
            1:       bits[15:13] = 3'b101;
            2:       bits[15:11] = 5'b11010;
            3:       bits[15:11] = 5'b11011;
            default: bits[15:13] = 3'b111;
        endcase
        w = bits;
        return w;
    endfunction

    task automatic issueInstr(input aluPkg::instrWord w, input aluPkg::operandPair ops);
        @(posedge clk);
        issue    <= 1'b1;
        instr    <= w;
        operands <= ops;
        wantQ.push_back(expectOf(w, ops));
        dueQ.push_back(edgeCount + 3);              // Drive edge plus two capture edges
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            issue <= 1'b0;
        end
    endtask

    task automatic drain();
        idleCycles(1);
        while (wantQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic collectResult();
        aluPkg::writeBack want;
        if (resultValid) begin
            if (wantQ.size() == 0) begin
                $display("Result valid with no instruction in flight");
                stopRun();
            end else begin
                want = wantQ.pop_front();
                checkEq("result latency", edgeCount, dueQ.pop_front());
                checkEq("wb.result", wb.result, want.result);
                checkEq("wb.writeEn", wb.writeEn, want.writeEn);
                checkEq("wb.illegal", wb.illegal, want.illegal);
                if (want.writeEn) begin
                    checkEq("wb.rd", wb.rd, want.rd);
                end
                lastWb   = wb;
                haveLast = 1'b1;
            end
        end else if (dueQ.size() != 0 && dueQ[0] <= edgeCount) begin
            $display("An issued instruction gave no result two cycles later");
            stopRun();
        end else if (haveLast) begin
            checkEq("wb held", wb, lastWb);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            collectResult();
        end
    end

    task automatic testReset();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkEq("resultValid after reset", resultValid, 1'b0);
        checkEq("wb.writeEn after reset", wb.writeEn, 1'b0);
        checkEq("wb.illegal after reset", wb.illegal, 1'b0);
        issueInstr(makeI(5'b01000, 3'd1, 3'd2, 5'd9), makeOps(16'h1234, 16'h0000));
        drain();
    endtask

    task automatic testArith();
        logic [4:0] imms [6];
        imms = '{5'd0, 5'd7, 5'd15, 5'h10, 5'h13, 5'h1f};  // Upper three negative when signed
        for (int m = 0; m < 4; m++) begin
            for (int k = 0; k < 6; k++) begin
                issueInstr(makeI({3'b010, 2'(m)}, 3'(k), 3'(m), imms[k]),
                           makeOps(randWord(), randWord()));
            end
            for (int k = 0; k < 4; k++) begin
                issueInstr(makeR(5'b11011, 3'(k), 3'(m), 3'(k + m), 2'(m)),
                           makeOps(randWord(), randWord()));
            end
        end
        // Small values where a reversed subtract is obvious
        issueInstr(makeR(5'b11011, 3'd1, 3'd2, 3'd3, 2'b01), makeOps(16'h0003, 16'h000a));
        issueInstr(makeI(5'b01001, 3'd1, 3'd4, 5'h1e), makeOps(16'h0005, 16'h0000));
        drain();
    endtask

    task automatic testShift();
        logic [15:0] noise;
        for (int amt = 0; amt < 16; amt++) begin
            for (int s = 0; s < 4; s++) begin
                noise = randWord();
                // Bit 4 of the immediate must not change the amount
                issueInstr(makeI({3'b101, 2'(s)}, 3'd2, 3'(s), {noise[0], 4'(amt)}),
                           makeOps(randWord(), 16'h0000));
                issueInstr(makeR(5'b11010, 3'd2, 3'd4, 3'(s), 2'(s)),
                           makeOps(randWord(), {noise[15:4], 4'(amt)}));
            end
        end
        drain();
    endtask

    task automatic testCond();
        logic [15:0] edgeA [6];
        logic [15:0] edgeB [6];
        logic [15:0] x;
        edgeA = '{16'h8000, 16'h7fff, 16'h1234, 16'hffff, 16'h0001, 16'h0000};
        edgeB = '{16'h7fff, 16'h8000, 16'h1234, 16'h0001, 16'hffff, 16'h0000};
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 6; k++) begin
                issueInstr(makeI({3'b111, 2'(s)}, 3'd3, 3'(k), 5'(k)),
                           makeOps(edgeA[k], edgeB[k]));
            end
            for (int k = 0; k < 8; k++) begin
                x = randWord();
                issueInstr(makeI({3'b111, 2'(s)}, 3'd5, 3'(k), 5'(k)),
                           makeOps(x, (k % 2 == 1) ? x : randWord()));   // Odd ones equal
            end
        end
        drain();
    endtask

    task automatic testIllegal();
        logic [4:0]  badOps [5];
        logic [4:0]  op;
        logic [15:0] noise;
        badOps = '{5'b00100, 5'b01100, 5'b10000, 5'b11000, 5'b11001};
        for (int k = 0; k < 5; k++) begin
            for (int n = 0; n < 4; n++) begin
                noise = randWord();
                op    = (k < 3) ? {badOps[k][4:2], noise[12:11]} : badOps[k];
                issueInstr(makeI(op, noise[10:8], noise[7:5], noise[4:0]),
                           makeOps(randWord(), randWord()));
            end
        end
        for (int n = 0; n < 4; n++) begin
            noise = randWord();
            issueInstr(makeI(5'b00000, noise[10:8], noise[7:5], noise[4:0]),
                       makeOps(randWord(), randWord()));
        end
        drain();
    endtask

    task automatic testPipeline();
        for (int k = 0; k < 40; k++) begin
            issueInstr(randomLegal(), makeOps(randWord(), randWord()));
        end
        idleCycles(3);                              // Must show as a gap in resultValid
        for (int k = 0; k < 3; k++) begin
            issueInstr(randomLegal(), makeOps(randWord(), randWord()));
        end
        drain();
    endtask

    initial begin
        rst      = 1'b1;
        issue    = 1'b0;
        instr    = '0;
        operands = '0;
        testReset();
        testArith();
        testShift();
        testCond();
        testIllegal();
        testPipeline();
        if (errorCount == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stopRun();
        end
    end

endmodule

// File: all.f
hdl/aluPkg.sv
hdl/claAdder16.sv
hdl/barrelShift16.sv
hdl/instrDecode.sv
hdl/alu.sv
hdl/executeStage.sv
testbench/executeStageTb.sv
